//--- hw/video_pkg.sv
// video package: vga timing, console geometry, pixel and colour types, palette
package video_pkg;

  // ----------------------------------------
  // 640x480 at 25 MHz line and frame shape
  // ----------------------------------------
  localparam int h_visible = 640;
  localparam int h_front   = 16;
  localparam int h_sync    = 96;
  localparam int h_back    = 48;
  localparam int v_visible = 480;
  localparam int v_front   = 10;
  localparam int v_sync    = 2;
  localparam int v_back    = 33;

  // console geometry
  localparam int tia_width       = 160;
  // console row where holding back may begin
  localparam int stall_start_row = 36;

  typedef logic [9:0] vga_pos_t;
  typedef logic [7:0] tia_x_t;
  typedef logic [8:0] tia_y_t;

  // hue in the upper nibble, luma below
  typedef struct packed {
    logic [3:0] hue;
    logic [2:0] luma;
  } pixel_code_t;

  typedef struct packed {
    logic [1:0] r;
    logic [1:0] g;
    logic [1:0] b;
  } rgb2_t;

  typedef struct packed {
    tia_x_t      x;
    tia_y_t      y;
    pixel_code_t code;
    logic        vsync;
    logic        vblank;
  } tia_pixel_t;

  // full brightness rgb per hue, luma scales it down
  localparam logic [23:0] palette_base [16] = '{
    24'hffffff, 24'hffff40, 24'hffa020, 24'hff6030,
    24'hff3050, 24'hff30c0, 24'hc030ff, 24'h7030ff,
    24'h3040ff, 24'h3080ff, 24'h30c0ff, 24'h30ffd0,
    24'h30ff60, 24'h80ff30, 24'hc0ff30, 24'hffd030
  };

endpackage

//--- hw/io_pkg.sv
// io package: pmod pin layouts, joystick word and audio level types
package io_pkg;

  // pmod input byte as joystick port, all active low
  typedef struct packed {
    logic start;
    logic switch_latch_n;
    logic select;
    logic fire;
    logic right;
    logic left;
    logic down;
    logic up;
  } atari_pins_t;

  // same byte seen as console switches
  typedef struct packed {
    logic [3:0] spare;
    logic [3:0] value;
  } switch_pins_t;

  // low nibble is both directions and switch bits
  typedef union packed {
    atari_pins_t  atari;
    switch_pins_t sw;
  } pmod_pins_u;

  // console joystick word
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic select;
    logic fire;
    logic reset;
  } joy_t;

  // tiny vga pmod bit order
  typedef struct packed {
    logic hsync;
    logic b0;
    logic g0;
    logic r0;
    logic vsync;
    logic b1;
    logic g1;
    logic r1;
  } vga_pmod_t;

  localparam int audio_width = 5;
  typedef logic [audio_width-1:0] audio_level_t;

endpackage

//--- hw/vga_timing.sv
// vga timing generator: 640x480 beam counters, sync pulses and visible flag
`timescale 1ns/1ps

module vga_timing
  import video_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  output vga_pos_t vga_x,
  output vga_pos_t vga_y,
  output logic     hsync,
  output logic     vsync,
  output logic     display_on
);

  // 800 clocks per line, 525 lines per frame
  localparam int h_total = h_visible + h_front + h_sync + h_back;
  localparam int v_total = v_visible + v_front + v_sync + v_back;

  // sync windows start right after the front porch
  localparam int h_sync_start = h_visible + h_front;
  localparam int v_sync_start = v_visible + v_front;

  logic line_end;
  assign line_end = (vga_x == vga_pos_t'(h_total - 1));

  // ----------------------------------------
  // counters
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga_x <= '0;
      vga_y <= '0;
    end else if (line_end) begin
      vga_x <= '0;
      // wrap frame on last line
      if (vga_y == vga_pos_t'(v_total - 1))
        vga_y <= '0;
      else
        vga_y <= vga_y + 10'd1;
    end else begin
      vga_x <= vga_x + 10'd1;
    end
  end

  // active low pulses, high everywhere else
  assign hsync = !((vga_x >= vga_pos_t'(h_sync_start)) &&
                   (vga_x <  vga_pos_t'(h_sync_start + h_sync)));
  assign vsync = !((vga_y >= vga_pos_t'(v_sync_start)) &&
                   (vga_y <  vga_pos_t'(v_sync_start + v_sync)));

  // visible 640x480 area
  assign display_on = (vga_x < vga_pos_t'(h_visible)) && (vga_y < vga_pos_t'(v_visible));

endmodule

//--- hw/scan_control.sv
// scan control: buffer addressing, beam blanking and console stall
`timescale 1ns/1ps

module scan_control
  import video_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  tia_pixel_t tia,
  input  vga_pos_t   vga_x,
  input  vga_pos_t   vga_y,
  input  logic       display_on,
  output logic       wr_en,
  output tia_x_t     wr_addr,
  output tia_x_t     rd_addr,
  output logic       show_pixel,
  output logic       stall
);

  logic     console_ahead;
  vga_pos_t tia_y_x2;

  // ----------------------------------------
  // write side, console rate
  // ----------------------------------------
  // only visible console columns land in the buffer
  assign wr_en   = (tia.x < tia_x_t'(tia_width));
  assign wr_addr = tia.x;

  // ----------------------------------------
  // read side, vga rate
  // ----------------------------------------
  // four vga pixels per console pixel
  assign rd_addr    = vga_x[9:2];
  assign show_pixel = display_on && !tia.vblank && (rd_addr < tia_x_t'(tia_width));

  // each console row covers two vga lines
  assign tia_y_x2 = {tia.y, 1'b0};

  // console row ahead of half the beam row
  assign console_ahead = (tia.y > tia_y_t'(stall_start_row)) && (vga_y < tia_y_x2);
  assign stall         = rst_n && console_ahead;

endmodule

//--- hw/scanline_buffer.sv
// scanline buffer: one console line of pixel codes, console write and vga read
`timescale 1ns/1ps

module scanline_buffer
  import video_pkg::*;
#(
  parameter int scanline_depth = 256
) (
  input  logic        clk,
  input  logic        wr_en,
  input  tia_x_t      wr_addr,
  input  pixel_code_t wr_code,
  input  tia_x_t      rd_addr,
  output pixel_code_t rd_code
);

  // storage, contents undefined until first write
  pixel_code_t line_mem [scanline_depth];

  // write lands on next edge
  always_ff @(posedge clk) begin
    if (wr_en)
      line_mem[wr_addr] <= wr_code;
  end

  // async read so the beam sees the code in the same cycle
  assign rd_code = line_mem[rd_addr];

endmodule

//--- hw/color_map.sv
// colour mapper: palette lookup, luma scaling and registered vga pmod byte
`timescale 1ns/1ps

module color_map
  import video_pkg::*;
  import io_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  pixel_code_t code,
  input  logic        show_pixel,
  input  logic        hsync,
  input  logic        vsync,
  output vga_pmod_t   vga
);

  logic [23:0] base_rgb;
  rgb2_t       colour;

  // channel times (luma + 1) over 8, top two bits
  function automatic logic [1:0] scale_top2(input logic [7:0] ch, input logic [2:0] luma);
    logic [10:0] prod;
    logic [7:0]  scaled;
    prod   = ch * ({1'b0, luma} + 4'd1);
    scaled = prod[10:3];
    return scaled[7:6];
  endfunction

  // ----------------------------------------
  // lookup and scale
  // ----------------------------------------
  assign base_rgb = palette_base[code.hue];

  always_comb begin
    colour = '0;
    // blank outside the picture
    if (show_pixel) begin
      colour.r = scale_top2(base_rgb[23:16], code.luma);
      colour.g = scale_top2(base_rgb[15:8], code.luma);
      colour.b = scale_top2(base_rgb[7:0], code.luma);
    end
  end

  // ----------------------------------------
  // output register, syncs delayed alongside
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga <= '{hsync: 1'b1, vsync: 1'b1, default: 1'b0};
    end else begin
      vga <= '{hsync: hsync, b0: colour.b[0], g0: colour.g[0], r0: colour.r[0],
               vsync: vsync, b1: colour.b[1], g1: colour.g[1], r1: colour.r[1]};
    end
  end

endmodule

//--- hw/audio_pwm.sv
// audio pwm: first order accumulator turning the 5-bit level into one bit
`timescale 1ns/1ps

module audio_pwm
  import io_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  audio_level_t level,
  output logic         pwm
);

  // low bits hold the remainder, top bit is the carry
  logic [audio_width:0] acc;

  always_ff @(posedge clk) begin
    if (!rst_n)
      acc <= '0;
    else
      acc <= {1'b0, acc[audio_width-1:0]} + {1'b0, level};
  end

  // high L times per 32 cycles
  assign pwm = acc[audio_width];

endmodule

//--- hw/joystick_input.sv
// joystick input: pmod pin remap to console joystick word and switch latch
`timescale 1ns/1ps

module joystick_input
  import io_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  pmod_pins_u pins,
  output joy_t       joystick,
  output logic [3:0] switches
);

  // ----------------------------------------
  // joystick word, all levels stay active low
  // ----------------------------------------
  always_comb begin
    joystick.right  = pins.atari.right;
    joystick.left   = pins.atari.left;
    joystick.down   = pins.atari.down;
    joystick.up     = pins.atari.up;
    joystick.select = pins.atari.select;
    joystick.fire   = pins.atari.fire;
    // start button doubles as console reset
    joystick.reset  = pins.atari.start;
  end

  // ----------------------------------------
  // switch latch
  // ----------------------------------------
  // low nibble read as switches while latch pin is pulled low
  always_ff @(posedge clk) begin
    if (!rst_n)
      switches <= 4'b1111;
    else if (!pins.atari.switch_latch_n)
      switches <= pins.sw.value;
  end

endmodule

//--- hw/tia_vga_top.sv
// scan converter top: console pixel stream to vga pmod, plus audio and inputs
`timescale 1ns/1ps

module tia_vga_top
  import video_pkg::*;
  import io_pkg::*;
#(
  parameter int scanline_depth = 256
) (
  input  logic         clk,
  input  logic         rst_n,
  input  tia_pixel_t   tia,
  input  audio_level_t audio,
  input  pmod_pins_u   pins,
  output vga_pmod_t    vga,
  output logic         audio_out,
  output joy_t         joystick,
  output logic [3:0]   switches,
  output logic         stall
);

  // ----------------------------------------
  // beam position and syncs
  // ----------------------------------------
  vga_pos_t    vga_x;
  vga_pos_t    vga_y;
  logic        hsync;
  logic        vsync;
  logic        display_on;

  // buffer control
  logic        wr_en;
  tia_x_t      wr_addr;
  tia_x_t      rd_addr;
  logic        show_pixel;
  pixel_code_t rd_code;

  vga_timing i_vga_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .vga_x      (vga_x),
    .vga_y      (vga_y),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on)
  );

  scan_control i_scan_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .tia        (tia),
    .vga_x      (vga_x),
    .vga_y      (vga_y),
    .display_on (display_on),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .rd_addr    (rd_addr),
    .show_pixel (show_pixel),
    .stall      (stall)
  );

  // one console line, replayed on two vga lines
  scanline_buffer #(
    .scanline_depth (scanline_depth)
  ) i_scanline_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_code (tia.code),
    .rd_addr (rd_addr),
    .rd_code (rd_code)
  );

  color_map i_color_map (
    .clk        (clk),
    .rst_n      (rst_n),
    .code       (rd_code),
    .show_pixel (show_pixel),
    .hsync      (hsync),
    .vsync      (vsync),
    .vga        (vga)
  );

  // ----------------------------------------
  // audio and player inputs
  // ----------------------------------------
  audio_pwm i_audio_pwm (
    .clk   (clk),
    .rst_n (rst_n),
    .level (audio),
    .pwm   (audio_out)
  );

  joystick_input i_joystick_input (
    .clk      (clk),
    .rst_n    (rst_n),
    .pins     (pins),
    .joystick (joystick),
    .switches (switches)
  );

endmodule

//--- test/tb_tia_vga.sv
// testbench for the tia to vga scan converter covering syncs, colour, blanking, stall, audio and inputs
`timescale 1ns/1ps

module tb_tia_vga
  import video_pkg::*;
  import io_pkg::*;
();

  localparam int h_total    = h_visible + h_front + h_sync + h_back;
  localparam int v_total    = v_visible + v_front + v_sync + v_back;
  // beam column one cycle after the registered hsync edge
  localparam int h_fall_col = h_visible + h_front + 1;

  // dut ports
  logic         clk = 1'b0;
  logic         rst_n;
  tia_pixel_t   tia;
  audio_level_t audio;
  pmod_pins_u   pins;
  vga_pmod_t    vga;
  logic         audio_out;
  joy_t         joystick;
  logic [3:0]   switches;
  logic         stall;

  // stimulus words hold the code in 15:8 and the expected colour in 7:0
  logic [15:0] stim_mem [16];

  int          errors;
  int          checks;
  logic        timed_out;
  int unsigned seed_init;

  // beam tracking and negedge snapshot
  int         beam_x;
  int         beam_y;
  int         pix_x;
  int         pix_y;
  logic       pix_valid;
  logic       pix_vblank;
  logic       vblank_prev;
  logic       locked;
  logic [5:0] snap_rgb;
  logic       snap_hs;
  logic       snap_vs;
  logic       snap_stall;
  int         snap_tia_y;
  logic       snap_audio;
  logic [6:0] snap_joy;
  logic [3:0] snap_sw;

  // sync shape counters
  logic hs_prev;
  logic vs_prev;
  int   hs_period;
  int   hs_low;
  int   hs_falls;
  int   vs_period;
  int   vs_low;
  int   vs_falls;
  int   vs_rises;

  tia_vga_top #(
    .scanline_depth (256)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .tia       (tia),
    .audio     (audio),
    .pins      (pins),
    .vga       (vga),
    .audio_out (audio_out),
    .joystick  (joystick),
    .switches  (switches),
    .stall     (stall)
  );

  always #5 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    timed_out = 1'b1;
  endtask

  // console joystick word from the raw active low pin byte
  function automatic logic [6:0] joy_remap(input logic [7:0] p);
    // right, left, down, up, select, fire, start as reset
    return {p[3], p[2], p[1], p[0], p[5], p[4], p[7]};
  endfunction

  // ----------------------------------------
  // negedge monitor where outputs are settled
  // ----------------------------------------
  always @(negedge clk) begin
    // registered output shows the beam of the cycle before
    pix_x       = beam_x;
    pix_y       = beam_y;
    pix_valid   = locked;
    pix_vblank  = vblank_prev;
    vblank_prev = tia.vblank;
    if (beam_x == h_total - 1) begin
      beam_x = 0;
      beam_y = (beam_y == v_total - 1) ? 0 : beam_y + 1;
    end else begin
      beam_x = beam_x + 1;
    end
    snap_rgb   = {vga.r1, vga.r0, vga.g1, vga.g0, vga.b1, vga.b0};
    snap_hs    = vga.hsync;
    snap_vs    = vga.vsync;
    snap_stall = stall;
    snap_tia_y = int'(tia.y);
    snap_audio = audio_out;
    snap_joy   = joystick;
    snap_sw    = switches;
    if (rst_n) begin
      hs_period++;
      vs_period++;
      // hsync falling edge realigns the column
      if (hs_prev && !vga.hsync) begin
        if (hs_falls > 0)
          compare_value("hsync period", h_total, hs_period);
        if (locked)
          compare_value("hsync phase", h_fall_col, beam_x);
        hs_falls++;
        hs_period = 0;
        hs_low    = 0;
        beam_x    = h_fall_col;
      end
      if (!vga.hsync)
        hs_low++;
      if (!hs_prev && vga.hsync && hs_falls > 0)
        compare_value("hsync low cycles", h_sync, hs_low);
      // vsync falls at column 0 of the first sync line
      if (vs_prev && !vga.vsync) begin
        if (vs_falls > 0)
          compare_value("vsync period", v_total * h_total, vs_period);
        if (locked)
          compare_value("vsync phase", v_visible + v_front, beam_y);
        vs_falls++;
        vs_period = 0;
        vs_low    = 0;
        beam_x    = 1;
        beam_y    = v_visible + v_front;
        locked    = 1'b1;
      end
      if (!vga.vsync)
        vs_low++;
      if (!vs_prev && vga.vsync && vs_falls > 0) begin
        compare_value("vsync low cycles", v_sync * h_total, vs_low);
        vs_rises++;
      end
    end
    hs_prev = vga.hsync;
    vs_prev = vga.vsync;
  end

  // one clock with the blanking rule checked on every sample
  task automatic next_cycle();
    @(posedge clk);
    if (pix_vblank)
      compare_value("vga colour in console vblank", 0, snap_rgb);
    else if (pix_valid && (pix_x >= h_visible || pix_y >= v_visible))
      compare_value("vga colour in beam blanking", 0, snap_rgb);
  endtask

  // ----------------------------------------
  // test phases
  // ----------------------------------------
  task automatic apply_reset();
    int i;
    for (i = 0; i < 5; i++) begin
      next_cycle();
      if (i > 0) begin
        compare_value("vga.hsync", 1, snap_hs);
        compare_value("vga.vsync", 1, snap_vs);
        compare_value("stall", 0, snap_stall);
      end
    end
    rst_n <= 1'b1;
    tia.y <= '0;
    // syncs idle high at the start of the frame
    for (i = 0; i < 4; i++) begin
      next_cycle();
      compare_value("vga.hsync", 1, snap_hs);
      compare_value("vga.vsync", 1, snap_vs);
      compare_value("switches", 4'hf, snap_sw);
    end
  endtask

  task automatic exercise_inputs();
    int         i;
    logic [7:0] p;
    logic [7:0] q;
    // switches keep their reset value while the latch pin is high
    for (i = 0; i < 8; i++) begin
      p    = 8'($urandom);
      p[6] = 1'b1;
      next_cycle();
      pins <= p;
      next_cycle();
      next_cycle();
      compare_value("joystick", joy_remap(p), snap_joy);
      compare_value("switches", 4'hf, snap_sw);
    end
    for (i = 0; i < 4; i++) begin
      p    = 8'($urandom);
      p[6] = 1'b0;
      next_cycle();
      pins <= p;
      next_cycle();
      next_cycle();
      compare_value("joystick", joy_remap(p), snap_joy);
      compare_value("switches", p[3:0], snap_sw);
      // latch released with a different nibble
      q      = 8'($urandom);
      q[6]   = 1'b1;
      q[3:0] = ~p[3:0];
      next_cycle();
      pins <= q;
      next_cycle();
      next_cycle();
      compare_value("joystick", joy_remap(q), snap_joy);
      compare_value("switches", p[3:0], snap_sw);
    end
    next_cycle();
    pins <= 8'hff;
  endtask

  task automatic measure_audio();
    int         i;
    int         n;
    int         ones;
    logic [4:0] lvl;
    for (i = 0; i < 8; i++) begin
      if (i == 0)
        lvl = 5'd0;
      else if (i == 1)
        lvl = 5'd31;
      else
        lvl = 5'($urandom % 32);
      next_cycle();
      audio <= lvl;
      // flush carries from the old level
      repeat (3) next_cycle();
      ones = 0;
      for (n = 0; n < 32; n++) begin
        next_cycle();
        ones = ones + int'(snap_audio);
      end
      compare_value("audio_out high count", lvl, ones);
    end
  endtask

  task automatic await_vsync();
    int n;
    for (n = 0; n < 2 * v_total * h_total && !locked; n++)
      next_cycle();
    if (!locked)
      report_timeout("no vsync pulse seen on the vga output");
  endtask

  // one console line during vertical blanking
  task automatic fill_scanline();
    int i;
    for (i = 0; i < tia_width; i++) begin
      next_cycle();
      tia.x      <= tia_x_t'(i);
      tia.code   <= stim_mem[i % 16][14:8];
      tia.vblank <= 1'b0;
    end
    next_cycle();
    tia.x <= 8'hff;
  endtask

  task automatic await_frame_start();
    int n;
    for (n = 0; n < v_total * h_total && !(pix_x == 0 && pix_y == 0); n++)
      next_cycle();
    if (!(pix_x == 0 && pix_y == 0))
      report_timeout("beam never reached the first visible line");
  endtask

  // lines 0 and 1 both replay the stored console line
  task automatic verify_first_lines();
    int n;
    for (n = 0; n < 2 * h_total; n++) begin
      // four neighbouring columns share one code
      if (pix_x < h_visible)
        compare_value("vga colour", stim_mem[(pix_x / 4) % 16][5:0], snap_rgb);
      next_cycle();
    end
  endtask

  task automatic sweep_stall();
    int   step;
    int   n;
    int   ty;
    logic exp_stall;
    // console blanked from here so visible lines stay black
    next_cycle();
    tia.vblank <= 1'b1;
    for (step = 0; step < 600; step++) begin
      // mostly rows near half the beam line and now and then anywhere
      if (step % 7 == 3)
        ty = int'($urandom % 512);
      else
        ty = beam_y / 2 + step % 5 - 2;
      if (ty < 0)
        ty = 0;
      next_cycle();
      tia.y <= tia_y_t'(ty);
      for (n = 0; n < 400; n++) begin
        next_cycle();
        exp_stall = (snap_tia_y > stall_start_row) && (beam_y < 2 * snap_tia_y);
        compare_value("stall", exp_stall, snap_stall);
      end
    end
    next_cycle();
    tia.y <= '0;
  endtask

  // second frame gives the vsync period and width checks
  task automatic await_second_vsync();
    int n;
    for (n = 0; n < v_total * h_total && vs_rises < 2; n++)
      next_cycle();
    if (vs_rises < 2)
      report_timeout("second vsync pulse did not complete");
  endtask

  initial begin
    seed_init   = $urandom(99);
    errors      = 0;
    checks      = 0;
    timed_out   = 1'b0;
    beam_x      = 0;
    beam_y      = 0;
    pix_x       = 0;
    pix_y       = 0;
    pix_valid   = 1'b0;
    pix_vblank  = 1'b0;
    vblank_prev = 1'b0;
    locked      = 1'b0;
    hs_prev     = 1'b1;
    vs_prev     = 1'b1;
    hs_period   = 0;
    hs_low      = 0;
    hs_falls    = 0;
    vs_period   = 0;
    vs_low      = 0;
    vs_falls    = 0;
    vs_rises    = 0;
    $readmemh("test/scan_stimulus.hex", stim_mem);
    // console idle off screen with a row that would stall outside reset
    rst_n      = 1'b0;
    tia        = '0;
    tia.x      = 8'hff;
    tia.y      = 9'd100;
    tia.vblank = 1'b1;
    audio      = '0;
    pins       = 8'hff;

    apply_reset();
    exercise_inputs();
    measure_audio();
    await_vsync();
    if (!timed_out)
      fill_scanline();
    if (!timed_out)
      await_frame_start();
    if (!timed_out)
      verify_first_lines();
    if (!timed_out)
      sweep_stall();
    if (!timed_out)
      await_second_vsync();

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, int'(timed_out));
    if (errors == 0 && !timed_out)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- test/scan_stimulus.hex
// one word per line: bits 15:8 pixel code {hue, luma}, bits 7:0 expected colour {r, g, b}
// colour is base rgb of the hue times (luma + 1) over 8, top two bits of each channel
073f
0315
0000
0f3d
1738
1d24
2731
2e32
3733
3c12
4707
4b05
570f
5a05
670d
7f3c

//--- filelist.f
hw/video_pkg.sv
hw/io_pkg.sv
hw/vga_timing.sv
hw/scan_control.sv
hw/scanline_buffer.sv
hw/color_map.sv
hw/audio_pwm.sv
hw/joystick_input.sv
hw/tia_vga_top.sv
test/tb_tia_vga.sv

//--- run_sim.sh
#!/bin/sh
# build and run the scan converter testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_tia_vga -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_tia_vga)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
